// ==== hdl/isaPkg.sv ====
// decode stage ISA definitions
`default_nettype none

package isaPkg;

   localparam int dataWidth    = 16;   // register, operand and instruction width
   localparam int regCount     = 8;
   localparam int regAddrWidth = 3;    // log2 of regCount
   localparam int opcodeWidth  = 5;    // major opcode lives in bits 15:11

   // major opcodes, 00010 and 00011 are unused and flag err
   typedef enum logic [opcodeWidth-1:0] {
      HALT   = 5'b00000,
      NOP    = 5'b00001,
      J      = 5'b00100,
      JR     = 5'b00101,
      JAL    = 5'b00110,
      JALR   = 5'b00111,
      ADDI   = 5'b01000,
      SUBI   = 5'b01001,
      XORI   = 5'b01010,
      ANDNI  = 5'b01011,
      BEQZ   = 5'b01100,
      BNEZ   = 5'b01101,
      BLTZ   = 5'b01110,
      BGEZ   = 5'b01111,
      ST     = 5'b10000,
      LD     = 5'b10001,
      SLBI   = 5'b10010,
      STU    = 5'b10011,
      ROLI   = 5'b10100,
      SLLI   = 5'b10101,
      RORI   = 5'b10110,
      SRLI   = 5'b10111,
      LBI    = 5'b11000,
      BTR    = 5'b11001,
      SHIFTR = 5'b11010,   // function in bits 1:0
      ARITHR = 5'b11011,   // function in bits 1:0
      SEQ    = 5'b11100,
      SLT    = 5'b11101,
      SLE    = 5'b11110,
      SCO    = 5'b11111
   } opcodeT;

   // ALU operations, encoded in declaration order
   typedef enum logic [3:0] {
      aluAdd, aluSub, aluXor, aluAndn,
      aluRol, aluSll, aluRor, aluSrl,
      aluSeq, aluSlt, aluSle, aluSco,
      aluBtr, aluPassB
   } aluOpT;

   typedef enum logic [1:0] {bReg = 2'b00, bImm5 = 2'b01, bImm11 = 2'b10, bZero = 2'b11} bSrcT;

   // destination field: rs 10:8, rt 7:5, rd 4:2, or fixed r7 for links
   typedef enum logic [1:0] {destRs = 2'b00, destRt = 2'b01, destRd = 2'b10, destR7 = 2'b11} destSelT;

   typedef enum logic [1:0] {wbAlu = 2'b00, wbMem = 2'b01, wbPc = 2'b10, wbImm = 2'b11} wbSelT;

   typedef enum logic [2:0] {brNone, brEqz, brNez, brLtz, brGez} brchT;

endpackage

`default_nettype wire

// ==== hdl/ctrlBus.sv ====
// datapath select bus
`timescale 1ns/1ps
`default_nettype none

interface ctrlBus
   import isaPkg::*;
   ();

   bSrcT    bSrc;      // B operand source
   logic    zeroSel;   // zero-extend imm5/imm8 instead of sign-extend
   destSelT destSel;   // which field names the destination register
   logic    stuSel;    // store data from the Rt read, not the B path

   // control unit side
   modport source (
      output bSrc,
      output zeroSel,
      output destSel,
      output stuSel
   );

   // operand selector side
   modport sink (
      input bSrc,
      input zeroSel,
      input destSel,
      input stuSel
   );

endinterface

`default_nettype wire

// ==== hdl/controlUnit.sv ====
// instruction control decoder
`timescale 1ns/1ps
`default_nettype none

module controlUnit
   import isaPkg::*;
   (
   input  logic [dataWidth-1:0] instruction,
   ctrlBus.source               ctrl,
   output logic                 memWrt,
   output logic                 readEn,
   output logic                 createDump,
   output logic                 SLBIsel,
   output logic                 immSrc,      // PC + imm11 for J and JAL
   output logic                 aluJmp,      // jump target comes from the ALU
   output logic                 aluPC,
   output logic                 jalSel,
   output logic                 sOpSel,      // immediate shift forms
   output logic                 Cin,
   output logic                 invA,
   output logic                 invB,
   output logic                 regWrtOut,
   output logic                 err,
   output wbSelT                wbDataSel,
   output brchT                 brchSig
   );

   opcodeT  opcode;
   logic    subFunct;   // ARITHR with function 01 is SUB
   bSrcT    bSrc;
   logic    zeroSel;
   destSelT destSel;
   logic    stuSel;

   assign opcode   = opcodeT'(instruction[15:11]);
   assign subFunct = (instruction[1:0] == 2'b01);

   always_comb begin
      // everything idles unless the opcode says otherwise
      memWrt     = 1'b0;
      createDump = 1'b0;
      SLBIsel    = 1'b0;
      immSrc     = 1'b0;
      aluJmp     = 1'b0;
      aluPC      = 1'b0;
      jalSel     = 1'b0;
      sOpSel     = 1'b0;
      Cin        = 1'b0;
      invA       = 1'b0;
      invB       = 1'b0;
      regWrtOut  = 1'b0;
      err        = 1'b0;
      wbDataSel  = wbAlu;
      brchSig    = brNone;
      bSrc       = bReg;
      zeroSel    = 1'b0;
      destSel    = destRs;
      stuSel     = 1'b0;

      case (opcode)
         HALT: createDump = 1'b1;
         NOP: ;
         J: begin
            immSrc = 1'b1;
            aluPC  = 1'b1;
         end
         JR: begin
            aluJmp = 1'b1;   // rs + imm8 computed by the ALU
            aluPC  = 1'b1;
            bSrc   = bZero;
         end
         JAL: begin
            immSrc    = 1'b1;
            aluPC     = 1'b1;
            jalSel    = 1'b1;
            regWrtOut = 1'b1;
            destSel   = destR7;   // link register
            wbDataSel = wbPc;
         end
         JALR: begin
            aluJmp    = 1'b1;
            aluPC     = 1'b1;
            jalSel    = 1'b1;
            regWrtOut = 1'b1;
            destSel   = destR7;
            wbDataSel = wbPc;
            bSrc      = bZero;
         end
         ADDI, SUBI, XORI, ANDNI: begin
            regWrtOut = 1'b1;
            destSel   = destRt;
            bSrc      = bImm5;
            invA      = (opcode == SUBI);   // imm - rs
            Cin       = (opcode == SUBI);
            zeroSel   = (opcode == XORI) || (opcode == ANDNI);   // logic ops take unsigned imm
         end
         ROLI, SLLI, RORI, SRLI: begin
            regWrtOut = 1'b1;
            destSel   = destRt;
            bSrc      = bImm5;
            sOpSel    = 1'b1;
         end
         BEQZ, BNEZ, BLTZ, BGEZ: begin
            bSrc = bZero;   // rs passes through for the zero test
            case (opcode)
               BEQZ:    brchSig = brEqz;
               BNEZ:    brchSig = brNez;
               BLTZ:    brchSig = brLtz;
               default: brchSig = brGez;
            endcase
         end
         ST: begin
            memWrt = 1'b1;
            bSrc   = bImm5;   // address = rs + imm5
            stuSel = 1'b1;
         end
         LD: begin
            regWrtOut = 1'b1;
            destSel   = destRt;
            bSrc      = bImm5;
            wbDataSel = wbMem;
         end
         STU: begin
            memWrt    = 1'b1;
            bSrc      = bImm5;
            stuSel    = 1'b1;
            regWrtOut = 1'b1;   // updated address back into rs
            destSel   = destRs;
         end
         SLBI: begin
            regWrtOut = 1'b1;
            destSel   = destRs;
            zeroSel   = 1'b1;
            SLBIsel   = 1'b1;
            wbDataSel = wbImm;
            bSrc      = bZero;
         end
         LBI: begin
            regWrtOut = 1'b1;
            destSel   = destRs;
            wbDataSel = wbImm;
            bSrc      = bZero;
         end
         BTR, SHIFTR, SCO: begin
            regWrtOut = 1'b1;
            destSel   = destRd;
         end
         ARITHR: begin
            regWrtOut = 1'b1;
            destSel   = destRd;
            invA      = subFunct;
            Cin       = subFunct;
         end
         SEQ, SLT, SLE: begin
            regWrtOut = 1'b1;
            destSel   = destRd;
            invB      = 1'b1;               // compare through rs - rt
            Cin       = (opcode != SEQ);
         end
         default: err = 1'b1;   // 00010, 00011
      endcase
   end

   assign readEn = (wbDataSel == wbMem);   // only loads touch memory for read

   assign ctrl.bSrc    = bSrc;
   assign ctrl.zeroSel = zeroSel;
   assign ctrl.destSel = destSel;
   assign ctrl.stuSel  = stuSel;

endmodule

`default_nettype wire

// ==== hdl/aluOpDecode.sv ====
// ALU operation decoder
`timescale 1ns/1ps
`default_nettype none

module aluOpDecode
   import isaPkg::*;
   (
   input  logic [dataWidth-1:0] instruction,
   output aluOpT                aluOp
   );

   opcodeT     opcode;
   logic [1:0] funct;   // R-format function field

   assign opcode = opcodeT'(instruction[15:11]);
   assign funct  = instruction[1:0];

   always_comb begin
      case (opcode)
         ADDI:  aluOp = aluAdd;
         SUBI:  aluOp = aluSub;
         XORI:  aluOp = aluXor;
         ANDNI: aluOp = aluAndn;
         ROLI:  aluOp = aluRol;
         SLLI:  aluOp = aluSll;
         RORI:  aluOp = aluRor;
         SRLI:  aluOp = aluSrl;
         SHIFTR: begin
            case (funct)
               2'b00:   aluOp = aluRol;
               2'b01:   aluOp = aluSll;
               2'b10:   aluOp = aluRor;
               default: aluOp = aluSrl;
            endcase
         end
         ARITHR: begin
            case (funct)
               2'b00:   aluOp = aluAdd;
               2'b01:   aluOp = aluSub;
               2'b10:   aluOp = aluXor;
               default: aluOp = aluAndn;
            endcase
         end
         SEQ: aluOp = aluSeq;
         SLT: aluOp = aluSlt;
         SLE: aluOp = aluSle;
         SCO: aluOp = aluSco;
         BTR: aluOp = aluBtr;
         // address and compare forms all run rs + B
         LD, ST, STU, BEQZ, BNEZ, BLTZ, BGEZ, JR, JALR: aluOp = aluAdd;
         default: aluOp = aluPassB;   // J, JAL, LBI, SLBI, HALT, NOP, illegal
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
// register file, two read one write
`timescale 1ns/1ps
`default_nettype none

module regFile
   import isaPkg::*;
   (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [regAddrWidth-1:0] rdAddrA,   // rs field
   input  logic [regAddrWidth-1:0] rdAddrB,   // rt field
   input  logic [regAddrWidth-1:0] wrAddr,
   input  logic [dataWidth-1:0]    wrData,
   input  logic                    wrEn,
   output logic [dataWidth-1:0]    rdDataA,
   output logic [dataWidth-1:0]    rdDataB
   );

   logic [dataWidth-1:0] regs [regCount];

   // write lands on the edge, visible to reads the cycle after
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // asynchronous reads, old value on a same-cycle write
   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

// ==== hdl/operandSelect.sv ====
// immediates and operand muxes
`timescale 1ns/1ps
`default_nettype none

module operandSelect
   import isaPkg::*;
   (
   input  logic [dataWidth-1:0]    instruction,
   input  logic [dataWidth-1:0]    regB,        // rt read
   ctrlBus.sink                    ctrl,
   output logic [dataWidth-1:0]    inB,
   output logic [dataWidth-1:0]    wrtData,
   output logic [dataWidth-1:0]    imm8,
   output logic [dataWidth-1:0]    imm11,
   output logic [regAddrWidth-1:0] wrtRegOut
   );

   logic [dataWidth-1:0] imm5;

   // zeroSel only affects the short immediates
   assign imm5  = ctrl.zeroSel ? {11'b0, instruction[4:0]}
                               : {{11{instruction[4]}}, instruction[4:0]};
   assign imm8  = ctrl.zeroSel ? {8'b0, instruction[7:0]}
                               : {{8{instruction[7]}}, instruction[7:0]};
   assign imm11 = {{5{instruction[10]}}, instruction[10:0]};   // always signed

   always_comb begin
      case (ctrl.bSrc)
         bReg:    inB = regB;
         bImm5:   inB = imm5;
         bImm11:  inB = imm11;   // kept for a full mux, not chosen today
         default: inB = '0;
      endcase
   end

   // ST and STU store the rt value, otherwise mirror inB
   assign wrtData = ctrl.stuSel ? regB : inB;

   always_comb begin
      case (ctrl.destSel)
         destRs:  wrtRegOut = instruction[10:8];
         destRt:  wrtRegOut = instruction[7:5];
         destRd:  wrtRegOut = instruction[4:2];
         default: wrtRegOut = 3'd7;   // link register for JAL/JALR
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
// decode stage top level
`timescale 1ns/1ps
`default_nettype none

module decode
   import isaPkg::*;
   (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [dataWidth-1:0]    instruction,
   input  logic [dataWidth-1:0]    wbData,      // write-back value
   input  logic                    regWrt,      // write-back enable
   input  logic [regAddrWidth-1:0] wrtReg,      // write-back target
   output logic [dataWidth-1:0]    imm8,
   output logic [dataWidth-1:0]    imm11,
   output logic [dataWidth-1:0]    inA,
   output logic [dataWidth-1:0]    inB,
   output logic [dataWidth-1:0]    wrtData,
   output aluOpT                   aluOp,
   output brchT                    brchSig,
   output wbSelT                   wbDataSel,
   output logic [regAddrWidth-1:0] wrtRegOut,
   output logic                    aluJmp,
   output logic                    SLBIsel,
   output logic                    createDump,
   output logic                    memWrt,
   output logic                    Cin,
   output logic                    invA,
   output logic                    invB,
   output logic                    immSrc,
   output logic                    jalSel,
   output logic                    sOpSel,
   output logic                    readEn,
   output logic                    aluPC,
   output logic                    regWrtOut,
   output logic                    err           // illegal opcode only
   );

   logic [dataWidth-1:0] regB;   // rt read, feeds B mux and store data

   ctrlBus ctrlIf ();

   controlUnit u_ctrl (
      .instruction (instruction), .ctrl (ctrlIf.source),
      .memWrt (memWrt), .readEn (readEn), .createDump (createDump), .SLBIsel (SLBIsel),
      .immSrc (immSrc), .aluJmp (aluJmp), .aluPC (aluPC), .jalSel (jalSel),
      .sOpSel (sOpSel), .Cin (Cin), .invA (invA), .invB (invB),
      .regWrtOut (regWrtOut), .err (err), .wbDataSel (wbDataSel), .brchSig (brchSig)
   );

   aluOpDecode u_aluOp (.instruction (instruction), .aluOp (aluOp));

   regFile u_regs (
      .clk (clk), .rstN (rstN),
      .rdAddrA (instruction[10:8]), .rdAddrB (instruction[7:5]), .wrAddr (wrtReg),
      .wrData (wbData), .wrEn (regWrt), .rdDataA (inA), .rdDataB (regB)
   );

   operandSelect u_opSel (
      .instruction (instruction), .regB (regB), .ctrl (ctrlIf.sink),
      .inB (inB), .wrtData (wrtData), .imm8 (imm8), .imm11 (imm11), .wrtRegOut (wrtRegOut)
   );

endmodule

`default_nettype wire

// ==== sim/decodeTb.sv ====
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module decodeTb
   import isaPkg::*;
   ();

   localparam int numRandom  = 640;                   // random cycles with the opcode swept mod 32
   localparam int testCycles = 3 + 8 + 2 + numRandom;  // reset, reset reads, directed, random

   // expected view of every decode output
   typedef struct packed {
      logic [15:0] inA, inB, wrtData, imm8, imm11;
      aluOpT       aluOp;
      brchT        brch;
      wbSelT       wbSel;
      logic [2:0]  wrtReg;
      logic        aluJmp, SLBIsel, createDump, memWrt, Cin, invA, invB;
      logic        immSrc, jalSel, sOpSel, readEn, aluPC, regWrt, err;
   } expT;

   logic        clk, rstN, regWrt;
   logic [15:0] instruction, wbData;
   logic [2:0]  wrtReg;
   logic [15:0] imm8, imm11, inA, inB, wrtData;
   aluOpT       aluOp;
   brchT        brchSig;
   wbSelT       wbDataSel;
   logic [2:0]  wrtRegOut;
   logic        aluJmp, SLBIsel, createDump, memWrt, Cin, invA, invB;
   logic        immSrc, jalSel, sOpSel, readEn, aluPC, regWrtOut, err;

   logic [15:0] shadowRegs [8];   // what the register file should hold
   logic [15:0] lfsrState;

   decode u_dut (
      .clk (clk), .rstN (rstN), .instruction (instruction), .wbData (wbData),
      .regWrt (regWrt), .wrtReg (wrtReg), .imm8 (imm8), .imm11 (imm11), .inA (inA),
      .inB (inB), .wrtData (wrtData), .aluOp (aluOp), .brchSig (brchSig),
      .wbDataSel (wbDataSel), .wrtRegOut (wrtRegOut), .aluJmp (aluJmp), .SLBIsel (SLBIsel),
      .createDump (createDump), .memWrt (memWrt), .Cin (Cin), .invA (invA), .invB (invB),
      .immSrc (immSrc), .jalSel (jalSel), .sOpSel (sOpSel), .readEn (readEn),
      .aluPC (aluPC), .regWrtOut (regWrtOut), .err (err)
   );

   always #5 clk = ~clk;   // 10 ns period

   // galois lfsr stepped once per bit
   function automatic logic takeBit();
      logic outBit;
      outBit    = lfsrState[0];
      lfsrState = {1'b0, lfsrState[15:1]} ^ (outBit ? 16'hB400 : 16'h0000);
      return outBit;
   endfunction

   function automatic logic [15:0] takeBits(input int n);
      logic [15:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val[i] = takeBit();
      end
      return val;
   endfunction

   // reference decode straight from the ISA rules
   function automatic expT modelDecode(input logic [15:0] ins);
      expT         e;
      logic [4:0]  op;
      logic [1:0]  fn;
      logic        isR, isImmAlu, isShiftI, isBr, zs;
      logic [15:0] imm5, rtVal;
      op       = ins[15:11];
      fn       = ins[1:0];
      isShiftI = op inside {ROLI, SLLI, RORI, SRLI};
      isImmAlu = isShiftI || (op inside {ADDI, SUBI, XORI, ANDNI});
      isR      = op inside {SHIFTR, ARITHR, SEQ, SLT, SLE, SCO};
      isBr     = op inside {BEQZ, BNEZ, BLTZ, BGEZ};
      zs       = op inside {XORI, ANDNI, SLBI};   // logical immediates are unsigned
      e        = '0;
      rtVal    = shadowRegs[ins[7:5]];
      e.inA    = shadowRegs[ins[10:8]];
      imm5     = zs ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
      e.imm8   = zs ? {8'b0, ins[7:0]} : {{8{ins[7]}}, ins[7:0]};
      e.imm11  = {{5{ins[10]}}, ins[10:0]};
      if (isImmAlu || (op inside {ST, LD, STU})) e.inB = imm5;
      else if (isBr || (op inside {JR, JALR, LBI, SLBI})) e.inB = '0;
      else e.inB = rtVal;
      e.wrtData = (op inside {ST, STU}) ? rtVal : e.inB;   // stores carry rt
      e.memWrt  = op inside {ST, STU};
      if (op == LD) e.wbSel = wbMem;
      else if (op inside {JAL, JALR}) e.wbSel = wbPc;
      else if (op inside {LBI, SLBI}) e.wbSel = wbImm;
      else e.wbSel = wbAlu;
      e.readEn = (op == LD);   // only loads read memory
      case (op)
         BEQZ:    e.brch = brEqz;
         BNEZ:    e.brch = brNez;
         BLTZ:    e.brch = brLtz;
         BGEZ:    e.brch = brGez;
         default: e.brch = brNone;
      endcase
      // destination field
      if (op inside {JAL, JALR}) e.wrtReg = 3'd7;
      else if (isR || op == BTR) e.wrtReg = ins[4:2];
      else if (isImmAlu || op == LD) e.wrtReg = ins[7:5];
      else e.wrtReg = ins[10:8];
      e.regWrt     = isR || isImmAlu || (op inside {LD, LBI, SLBI, BTR, JAL, JALR, STU});
      e.immSrc     = op inside {J, JAL};
      e.aluJmp     = op inside {JR, JALR};
      e.aluPC      = op inside {J, JR, JAL, JALR};
      e.jalSel     = op inside {JAL, JALR};
      e.SLBIsel    = (op == SLBI);
      e.createDump = (op == HALT);
      e.invA       = (op == SUBI) || (op == ARITHR && fn == 2'b01);
      e.Cin        = e.invA || (op inside {SLT, SLE});
      e.invB       = op inside {SEQ, SLT, SLE};
      e.sOpSel     = isShiftI;
      e.err        = op inside {5'b00010, 5'b00011};
      case (op)
         ADDI:    e.aluOp = aluAdd;
         SUBI:    e.aluOp = aluSub;
         XORI:    e.aluOp = aluXor;
         ANDNI:   e.aluOp = aluAndn;
         ROLI:    e.aluOp = aluRol;
         SLLI:    e.aluOp = aluSll;
         RORI:    e.aluOp = aluRor;
         SRLI:    e.aluOp = aluSrl;
         SHIFTR:  e.aluOp = (fn == 0) ? aluRol : (fn == 1) ? aluSll : (fn == 2) ? aluRor : aluSrl;
         ARITHR:  e.aluOp = (fn == 0) ? aluAdd : (fn == 1) ? aluSub : (fn == 2) ? aluXor : aluAndn;
         SEQ:     e.aluOp = aluSeq;
         SLT:     e.aluOp = aluSlt;
         SLE:     e.aluOp = aluSle;
         SCO:     e.aluOp = aluSco;
         BTR:     e.aluOp = aluBtr;
         LD, ST, STU, BEQZ, BNEZ, BLTZ, BGEZ, JR, JALR: e.aluOp = aluAdd;
         default: e.aluOp = aluPassB;
      endcase
      return e;
   endfunction

   task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic checkOutputs();
      expT e;
      e = modelDecode(instruction);
      check("inA", inA, e.inA);
      check("inB", inB, e.inB);
      check("wrtData", wrtData, e.wrtData);
      check("imm8", imm8, e.imm8);
      check("imm11", imm11, e.imm11);
      check("aluOp", aluOp, e.aluOp);
      check("brchSig", brchSig, e.brch);
      check("wbDataSel", wbDataSel, e.wbSel);
      check("wrtRegOut", wrtRegOut, e.wrtReg);
      check("aluJmp", aluJmp, e.aluJmp);
      check("SLBIsel", SLBIsel, e.SLBIsel);
      check("createDump", createDump, e.createDump);
      check("memWrt", memWrt, e.memWrt);
      check("Cin", Cin, e.Cin);
      check("invA", invA, e.invA);
      check("invB", invB, e.invB);
      check("immSrc", immSrc, e.immSrc);
      check("jalSel", jalSel, e.jalSel);
      check("sOpSel", sOpSel, e.sOpSel);
      check("readEn", readEn, e.readEn);
      check("aluPC", aluPC, e.aluPC);
      check("regWrtOut", regWrtOut, e.regWrt);
      check("err", err, e.err);
   endtask

   // drive 1 ns past the edge, check mid cycle, then commit the write
   task automatic driveCycle(input logic [15:0] ins, input logic [15:0] wd,
                             input logic [2:0] wr, input logic we);
      @(posedge clk);
      #1;
      instruction = ins;
      wbData      = wd;
      wrtReg      = wr;
      regWrt      = we;
      #4;
      checkOutputs();   // old contents until the write lands on the coming edge
      if (we) shadowRegs[wr] = wd;
   endtask

   initial begin
      #(testCycles * 10 + 100);
      $display("watchdog expired, the decode test hung before finishing");
      $display("Simulation failed");
      $fatal(1, "timeout");
   end

   initial begin
      logic [15:0] ins, wd, bits;
      logic [2:0]  wr;
      logic        we;
      clk         = 1'b0;
      rstN        = 1'b0;
      instruction = '0;
      wbData      = '0;
      wrtReg      = '0;
      regWrt      = 1'b0;
      lfsrState   = 16'd24;
      for (int i = 0; i < 8; i++) shadowRegs[i] = '0;
      repeat (3) @(posedge clk);
      #1 rstN = 1'b1;

      // every register cleared by reset
      for (int r = 0; r < 8; r++) begin
         driveCycle({NOP, 3'(r), 8'h00}, 16'h0, 3'd0, 1'b0);
         check("inA", inA, 16'h0000);
      end

      // write r3 while reading it, then read again
      driveCycle({ST, 3'd3, 3'd3, 5'd0}, 16'hA5C3, 3'd3, 1'b1);
      check("inA", inA, 16'h0000);   // same cycle still old
      driveCycle({ST, 3'd3, 3'd3, 5'd0}, 16'h0000, 3'd0, 1'b0);
      check("wrtData", wrtData, 16'hA5C3);

      // random operands with the opcode swept so every code recurs including illegal ones
      for (int i = 0; i < numRandom; i++) begin
         ins         = takeBits(16);
         ins[15:11]  = 5'(i);
         wd          = takeBits(16);
         bits        = takeBits(3);
         wr          = bits[2:0];
         bits        = takeBits(1);
         we          = bits[0];
         driveCycle(ins, wd, wr, we);
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/isaPkg.sv
hdl/ctrlBus.sv
hdl/controlUnit.sv
hdl/aluOpDecode.sv
hdl/regFile.sv
hdl/operandSelect.sv
hdl/decode.sv
sim/decodeTb.sv
